// ==== source/cache_pkg.sv ====
// cache shared types
`default_nettype none

package cache_pkg;

  // one data word on every port
  typedef logic [31:0] word_t;

  // one enable bit per byte lane of word_t
  typedef logic [3:0] byte_en_t;

  // refill controller states
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,  // waiting for a miss
    ST_WRITEBACK = 2'd1,  // dirty victim going out
    ST_FILL      = 2'd2   // new line coming in
  } refill_state_e;

endpackage

`default_nettype wire

// ==== source/cache_line.sv ====
// direct-mapped cache line
`timescale 1ns/1ps
`default_nettype none

module cache_line #(
  parameter int ADDR_WIDTH     = 32,
  parameter int TAG_WIDTH      = 20,
  parameter int LINE_OFF_WIDTH = 6
) (
  input  wire                        clk,
  input  wire                        rst_n,
  // lookup port A
  input  wire  [ADDR_WIDTH-1:0]      a_addr_i,
  output logic                       a_hit_o,
  output cache_pkg::word_t           a_data_o,
  // lookup port B
  input  wire  [ADDR_WIDTH-1:0]      b_addr_i,
  output logic                       b_hit_o,
  output cache_pkg::word_t           b_data_o,
  // write-back read
  input  wire  [LINE_OFF_WIDTH-3:0]  wb_off_i,
  output cache_pkg::word_t           wb_data_o,
  // line state
  output logic [TAG_WIDTH-1:0]       tag_o,
  output logic                       dirty_o,
  // write port
  input  wire                        wr_en_i,
  input  wire  [LINE_OFF_WIDTH-3:0]  wr_off_i,
  input  wire  [TAG_WIDTH-1:0]       wr_tag_i,
  input  wire                        wr_valid_i,
  input  wire                        wr_dirty_i,
  input  wire  cache_pkg::word_t     wr_data_i,
  input  wire  cache_pkg::byte_en_t  wr_be_i
);

  localparam int WOFF_WIDTH = LINE_OFF_WIDTH - 2;
  localparam int WORDS      = 2 ** WOFF_WIDTH;

  cache_pkg::word_t      data_q [WORDS];
  logic [TAG_WIDTH-1:0]  tag_q;
  logic                  valid_q;
  logic                  dirty_q;
  logic [WOFF_WIDTH-1:0] a_off;
  logic [WOFF_WIDTH-1:0] b_off;

  assign a_off = a_addr_i[LINE_OFF_WIDTH-1:2];  // word within line
  assign b_off = b_addr_i[LINE_OFF_WIDTH-1:2];

  assign a_hit_o = valid_q && (a_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH] == tag_q);
  assign b_hit_o = valid_q && (b_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH] == tag_q);

  assign a_data_o  = data_q[a_off];
  assign b_data_o  = data_q[b_off];
  assign wb_data_o = data_q[wb_off_i];

  assign tag_o   = tag_q;
  assign dirty_o = dirty_q;

  // merge enabled bytes and take the new tag
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_q <= wr_tag_i;
      for (int i = 0; i < 4; i++) begin
        if (wr_be_i[i]) begin
          data_q[wr_off_i][8*i +: 8] <= wr_data_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= wr_valid_i;  // low until last fill word
      dirty_q <= wr_dirty_i;
    end
  end

  // neither the host nor the refill path may send an empty write
  a_wr_be_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en_i |-> (wr_be_i != '0)
  ) else $error("cache_line: write issued with all byte enables low");

endmodule

`default_nettype wire

// ==== source/line_refill_ctrl.sv ====
// line refill controller
`timescale 1ns/1ps
`default_nettype none

module line_refill_ctrl #(
  parameter int ADDR_WIDTH     = 32,
  parameter int TAG_WIDTH      = 20,
  parameter int LINE_OFF_WIDTH = 6
) (
  input  wire                        clk,
  input  wire                        rst_n,
  // from the core
  input  wire                        miss_i,
  input  wire  [ADDR_WIDTH-1:0]      miss_addr_i,
  input  wire  [TAG_WIDTH-1:0]       victim_tag_i,
  input  wire                        victim_dirty_i,
  // to the core
  output logic                       fill_we_o,
  output logic [LINE_OFF_WIDTH-3:0]  fill_off_o,
  output logic                       fill_last_o,
  output logic [ADDR_WIDTH-TAG_WIDTH-LINE_OFF_WIDTH-1:0] fill_idx_o,
  output logic [TAG_WIDTH-1:0]       fill_tag_o,
  output logic [LINE_OFF_WIDTH-3:0]  wb_off_o,
  // burst master
  output logic [ADDR_WIDTH-1:0]      m_addr_o,
  output logic [LINE_OFF_WIDTH-2:0]  m_burstcount_o,
  output logic                       m_read_o,
  output logic                       m_write_o,
  input  wire  cache_pkg::word_t     m_readdata_i,
  input  wire                        m_waitrequest_i,
  input  wire                        m_readdatavalid_i
);

  localparam int IDX_WIDTH   = ADDR_WIDTH - TAG_WIDTH - LINE_OFF_WIDTH;
  localparam int LBASE_WIDTH = ADDR_WIDTH - LINE_OFF_WIDTH;
  localparam int WOFF_WIDTH  = LINE_OFF_WIDTH - 2;
  localparam int WORDS       = 2 ** WOFF_WIDTH;

  localparam logic [WOFF_WIDTH-1:0] LAST_OFF = '1;

  cache_pkg::refill_state_e state_q;
  logic [WOFF_WIDTH-1:0]    cnt_q;
  logic [LBASE_WIDTH-1:0]   line_q;  // tag and index of the missing line
  logic [IDX_WIDTH-1:0]     miss_idx;

  assign miss_idx = miss_addr_i[LINE_OFF_WIDTH +: IDX_WIDTH];

  assign m_burstcount_o = WORDS[LINE_OFF_WIDTH-2:0];  // always a full line

  assign fill_we_o   = (state_q == cache_pkg::ST_FILL) && m_readdatavalid_i;
  assign fill_last_o = fill_we_o && (cnt_q == LAST_OFF);
  assign fill_off_o  = cnt_q;
  assign wb_off_o    = cnt_q;

  assign fill_idx_o = line_q[IDX_WIDTH-1:0];
  assign fill_tag_o = line_q[LBASE_WIDTH-1 -: TAG_WIDTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= cache_pkg::ST_IDLE;
      cnt_q     <= '0;
      line_q    <= '0;
      m_addr_o  <= '0;
      m_read_o  <= 1'b0;
      m_write_o <= 1'b0;
    end else begin
      case (state_q)
        cache_pkg::ST_IDLE: begin
          if (miss_i) begin
            line_q <= miss_addr_i[ADDR_WIDTH-1:LINE_OFF_WIDTH];
            cnt_q  <= '0;
            if (victim_dirty_i) begin
              state_q   <= cache_pkg::ST_WRITEBACK;
              m_addr_o  <= {victim_tag_i, miss_idx, {LINE_OFF_WIDTH{1'b0}}};
              m_write_o <= 1'b1;
            end else begin
              state_q  <= cache_pkg::ST_FILL;
              m_addr_o <= {miss_addr_i[ADDR_WIDTH-1:LINE_OFF_WIDTH], {LINE_OFF_WIDTH{1'b0}}};
              m_read_o <= 1'b1;
            end
          end
        end

        cache_pkg::ST_WRITEBACK: begin
          if (!m_waitrequest_i) begin
            if (cnt_q == LAST_OFF) begin
              // victim is out, ask for the new line
              state_q   <= cache_pkg::ST_FILL;
              cnt_q     <= '0;
              m_write_o <= 1'b0;
              m_read_o  <= 1'b1;
              m_addr_o  <= {line_q, {LINE_OFF_WIDTH{1'b0}}};
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end

        cache_pkg::ST_FILL: begin
          if (m_read_o && !m_waitrequest_i) begin
            m_read_o <= 1'b0;  // request accepted
          end
          if (m_readdatavalid_i) begin
            cnt_q <= cnt_q + 1'b1;  // wraps to zero after the last word
            if (cnt_q == LAST_OFF) begin
              state_q <= cache_pkg::ST_IDLE;
            end
          end
        end

        default: begin
          state_q <= cache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  a_no_read_write: assert property (
    @(posedge clk) disable iff (!rst_n) !(m_read_o && m_write_o)
  ) else $error("line_refill_ctrl: master read and write strobes both high");

  // returned words only belong to an open fill burst
  a_rdata_in_fill: assert property (
    @(posedge clk) disable iff (!rst_n)
      m_readdatavalid_i |-> (state_q == cache_pkg::ST_FILL) && !$isunknown(m_readdata_i)
  ) else $error("line_refill_ctrl: read data outside a fill burst or unknown");

endmodule

`default_nettype wire

// ==== source/cache_core.sv ====
// write-back data cache top level
`timescale 1ns/1ps
`default_nettype none

module cache_core #(
  parameter int ADDR_WIDTH     = 32,
  parameter int TAG_WIDTH      = 20,
  parameter int LINE_OFF_WIDTH = 6
) (
  input  wire                        clk,
  input  wire                        rst_n,
  // port A, read and write
  input  wire  [ADDR_WIDTH-1:0]      a_addr_i,
  input  wire                        a_read_i,
  input  wire                        a_write_i,
  input  wire  cache_pkg::word_t     a_writedata_i,
  input  wire  cache_pkg::byte_en_t  a_byteenable_i,
  output cache_pkg::word_t           a_readdata_o,
  output logic                       a_waitrequest_o,
  // port B, read only
  input  wire  [ADDR_WIDTH-1:0]      b_addr_i,
  input  wire                        b_read_i,
  output cache_pkg::word_t           b_readdata_o,
  output logic                       b_waitrequest_o,
  // burst master
  output logic [ADDR_WIDTH-1:0]      m_addr_o,
  output logic [LINE_OFF_WIDTH-2:0]  m_burstcount_o,
  output logic                       m_read_o,
  output logic                       m_write_o,
  output cache_pkg::word_t           m_writedata_o,
  input  wire  cache_pkg::word_t     m_readdata_i,
  input  wire                        m_waitrequest_i,
  input  wire                        m_readdatavalid_i
);

  localparam int IDX_WIDTH  = ADDR_WIDTH - TAG_WIDTH - LINE_OFF_WIDTH;
  localparam int WOFF_WIDTH = LINE_OFF_WIDTH - 2;
  localparam int LINES      = 2 ** IDX_WIDTH;

  logic [TAG_WIDTH-1:0]  a_tag;
  logic [IDX_WIDTH-1:0]  a_idx;
  logic [WOFF_WIDTH-1:0] a_woff;
  logic [IDX_WIDTH-1:0]  b_idx;

  // per-line results
  logic [LINES-1:0]      a_hit_l;
  logic [LINES-1:0]      b_hit_l;
  logic [LINES-1:0]      dirty_l;
  logic [LINES-1:0]      wr_en_l;
  cache_pkg::word_t      a_data_l [LINES];
  cache_pkg::word_t      b_data_l [LINES];
  cache_pkg::word_t      wb_data_l [LINES];
  logic [TAG_WIDTH-1:0]  tag_l [LINES];

  logic                  a_hit;
  logic                  b_hit;
  logic                  a_miss;
  logic                  b_miss;
  logic                  a_stall;
  logic                  direct_we;

  logic [ADDR_WIDTH-1:0] miss_addr;
  logic [IDX_WIDTH-1:0]  miss_idx;

  // refill side
  logic                  fill_we;
  logic [WOFF_WIDTH-1:0] fill_off;
  logic                  fill_last;
  logic [IDX_WIDTH-1:0]  fill_idx;
  logic [TAG_WIDTH-1:0]  fill_tag;
  logic [WOFF_WIDTH-1:0] wb_off;

  // shared line write bus
  logic [WOFF_WIDTH-1:0] wr_off;
  logic [TAG_WIDTH-1:0]  wr_tag;
  logic                  wr_valid;
  logic                  wr_dirty;
  cache_pkg::word_t      wr_data;
  cache_pkg::byte_en_t   wr_be;

  assign a_tag  = a_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign a_idx  = a_addr_i[LINE_OFF_WIDTH +: IDX_WIDTH];
  assign a_woff = a_addr_i[LINE_OFF_WIDTH-1:2];
  assign b_idx  = b_addr_i[LINE_OFF_WIDTH +: IDX_WIDTH];

  assign a_hit        = a_hit_l[a_idx];
  assign b_hit        = b_hit_l[b_idx];
  assign a_readdata_o = a_data_l[a_idx];
  assign b_readdata_o = b_data_l[b_idx];

  assign a_miss = (a_read_i || a_write_i) && !a_hit;
  assign b_miss = b_read_i && !b_hit;

  // write hit waits while the bus carries a fill word or B is evicting this line
  assign a_stall   = a_write_i && a_hit && (fill_we || (b_miss && (b_idx == a_idx)));
  assign direct_we = a_write_i && a_hit && !a_stall;

  assign a_waitrequest_o = a_miss || a_stall;
  assign b_waitrequest_o = b_miss;

  assign miss_addr = a_miss ? a_addr_i : b_addr_i;  // A first
  assign miss_idx  = miss_addr[LINE_OFF_WIDTH +: IDX_WIDTH];

  assign wr_off   = direct_we ? a_woff : fill_off;
  assign wr_tag   = direct_we ? a_tag : fill_tag;
  assign wr_valid = direct_we || fill_last;
  assign wr_dirty = direct_we;
  assign wr_data  = direct_we ? a_writedata_i : m_readdata_i;
  assign wr_be    = direct_we ? a_byteenable_i : '1;

  assign m_writedata_o = wb_data_l[fill_idx];

  for (genvar i = 0; i < LINES; i++) begin : g_line
    assign wr_en_l[i] = (direct_we && (a_idx == IDX_WIDTH'(i)))
                     || (fill_we && (fill_idx == IDX_WIDTH'(i)));

    cache_line #(
      .ADDR_WIDTH     (ADDR_WIDTH),
      .TAG_WIDTH      (TAG_WIDTH),
      .LINE_OFF_WIDTH (LINE_OFF_WIDTH)
    ) i_line (
      .clk        (clk),
      .rst_n      (rst_n),
      .a_addr_i   (a_addr_i),
      .a_hit_o    (a_hit_l[i]),
      .a_data_o   (a_data_l[i]),
      .b_addr_i   (b_addr_i),
      .b_hit_o    (b_hit_l[i]),
      .b_data_o   (b_data_l[i]),
      .wb_off_i   (wb_off),
      .wb_data_o  (wb_data_l[i]),
      .tag_o      (tag_l[i]),
      .dirty_o    (dirty_l[i]),
      .wr_en_i    (wr_en_l[i]),
      .wr_off_i   (wr_off),
      .wr_tag_i   (wr_tag),
      .wr_valid_i (wr_valid),
      .wr_dirty_i (wr_dirty),
      .wr_data_i  (wr_data),
      .wr_be_i    (wr_be)
    );
  end

  line_refill_ctrl #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .TAG_WIDTH      (TAG_WIDTH),
    .LINE_OFF_WIDTH (LINE_OFF_WIDTH)
  ) i_refill (
    .clk               (clk),
    .rst_n             (rst_n),
    .miss_i            (a_miss || b_miss),
    .miss_addr_i       (miss_addr),
    .victim_tag_i      (tag_l[miss_idx]),
    .victim_dirty_i    (dirty_l[miss_idx]),
    .fill_we_o         (fill_we),
    .fill_off_o        (fill_off),
    .fill_last_o       (fill_last),
    .fill_idx_o        (fill_idx),
    .fill_tag_o        (fill_tag),
    .wb_off_o          (wb_off),
    .m_addr_o          (m_addr_o),
    .m_burstcount_o    (m_burstcount_o),
    .m_read_o          (m_read_o),
    .m_write_o         (m_write_o),
    .m_readdata_i      (m_readdata_i),
    .m_waitrequest_i   (m_waitrequest_i),
    .m_readdatavalid_i (m_readdatavalid_i)
  );

  // the line under refill never takes a direct write, so fill and host never collide
  a_no_write_to_refill_line: assert property (
    @(posedge clk) disable iff (!rst_n)
      (direct_we && (i_refill.state_q != cache_pkg::ST_IDLE)) |-> (a_idx != fill_idx)
  ) else $error("cache_core: direct write to the line being refilled");

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // released just after an edge
  end

endmodule

`default_nettype wire

// ==== bench/avalon_mem_model.sv ====
// burst memory slave model
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model #(
  parameter int ADDR_WIDTH = 32,
  parameter int BC_WIDTH   = 3,
  parameter int LATENCY    = 2,
  parameter int MAX_STALL  = 3
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire  [ADDR_WIDTH-1:0]  addr_i,
  input  wire  [BC_WIDTH-1:0]    burstcount_i,
  input  wire                    read_i,
  input  wire                    write_i,
  input  wire  cache_pkg::word_t writedata_i,
  output cache_pkg::word_t       readdata_o,
  output logic                   waitrequest_o,
  output logic                   readdatavalid_o
);

  cache_pkg::word_t      mem [logic [ADDR_WIDTH-3:0]];  // written words only
  logic [ADDR_WIDTH-3:0] rd_base;
  logic [ADDR_WIDTH-3:0] waddr;
  int                    wr_beat;
  int                    rd_beat;
  int                    rd_left;
  int                    rd_delay;
  int                    stall_cnt;

  // untouched words read as word address xor a fixed pattern
  function automatic cache_pkg::word_t word_at(input logic [ADDR_WIDTH-3:0] wa);
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return 32'(wa) ^ 32'h5A5A_0000;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waitrequest_o   <= 1'b0;
      readdatavalid_o <= 1'b0;
      readdata_o      <= '0;
      rd_base         <= '0;
      wr_beat         <= 0;
      rd_beat         <= 0;
      rd_left         <= 0;
      rd_delay        <= 0;
      stall_cnt       <= 0;
    end else begin
      if (stall_cnt < MAX_STALL && ($urandom % 4) == 0) begin
        waitrequest_o <= 1'b1;  // bounded random stall
        stall_cnt     <= stall_cnt + 1;
      end else begin
        waitrequest_o <= 1'b0;
        stall_cnt     <= 0;
      end

      if (write_i && !waitrequest_o) begin
        waddr      = addr_i[ADDR_WIDTH-1:2] + (ADDR_WIDTH-2)'(wr_beat);
        mem[waddr] = writedata_i;
        if (wr_beat == int'(burstcount_i) - 1) begin
          wr_beat <= 0;
        end else begin
          wr_beat <= wr_beat + 1;
        end
      end

      if (read_i && !waitrequest_o && rd_left == 0) begin
        rd_base  <= addr_i[ADDR_WIDTH-1:2];  // request accepted
        rd_left  <= int'(burstcount_i);
        rd_delay <= LATENCY;
        rd_beat  <= 0;
      end

      readdatavalid_o <= 1'b0;
      if (rd_left > 0) begin
        if (rd_delay > 0) begin
          rd_delay <= rd_delay - 1;
        end else begin
          waddr           = rd_base + (ADDR_WIDTH-2)'(rd_beat);
          readdata_o      <= word_at(waddr);
          readdatavalid_o <= 1'b1;
          rd_beat         <= rd_beat + 1;
          rd_left         <= rd_left - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_cache.sv ====
// data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int WORDS        = 4;
  localparam int LATENCY      = 2;
  localparam int MAX_STALL    = 3;
  localparam int NUM_RANDOM   = 40;
  // write-back and fill with every beat stalled, plus read latency and slack
  localparam int ENTRY_CYCLES = 2 * WORDS * (MAX_STALL + 1) + LATENCY + 8;

  typedef enum logic [1:0] {OP_A_RD, OP_A_WR, OP_B_RD} op_e;

  logic        clk;
  logic        rst_n;
  logic [31:0] a_addr;
  logic        a_read;
  logic        a_write;
  logic [31:0] a_writedata;
  logic [3:0]  a_byteenable;
  logic [31:0] a_readdata;
  logic        a_waitrequest;
  logic [31:0] b_addr;
  logic        b_read;
  logic [31:0] b_readdata;
  logic        b_waitrequest;
  logic [31:0] m_addr;
  logic [2:0]  m_burstcount;
  logic        m_read;
  logic        m_write;
  logic [31:0] m_writedata;
  logic [31:0] m_readdata;
  logic        m_waitrequest;
  logic        m_readdatavalid;

  string       tbl_name [$];
  op_e         tbl_op [$];
  logic [31:0] tbl_addr [$];
  logic [31:0] tbl_wdata [$];
  logic [3:0]  tbl_be [$];
  logic [31:0] shadow [logic [29:0]];  // words written so far
  logic [23:0] line_tag [16];  // tag each cache line should hold
  bit          line_valid [16];
  int          errors;
  int          failed_tests;
  bit          table_ready;

  clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cache_core #(.ADDR_WIDTH(32), .TAG_WIDTH(24), .LINE_OFF_WIDTH(4)) i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .a_addr_i          (a_addr),
    .a_read_i          (a_read),
    .a_write_i         (a_write),
    .a_writedata_i     (a_writedata),
    .a_byteenable_i    (a_byteenable),
    .a_readdata_o      (a_readdata),
    .a_waitrequest_o   (a_waitrequest),
    .b_addr_i          (b_addr),
    .b_read_i          (b_read),
    .b_readdata_o      (b_readdata),
    .b_waitrequest_o   (b_waitrequest),
    .m_addr_o          (m_addr),
    .m_burstcount_o    (m_burstcount),
    .m_read_o          (m_read),
    .m_write_o         (m_write),
    .m_writedata_o     (m_writedata),
    .m_readdata_i      (m_readdata),
    .m_waitrequest_i   (m_waitrequest),
    .m_readdatavalid_i (m_readdatavalid)
  );

  avalon_mem_model #(
    .ADDR_WIDTH (32),
    .BC_WIDTH   (3),
    .LATENCY    (LATENCY),
    .MAX_STALL  (MAX_STALL)
  ) i_mem (
    .clk             (clk),
    .rst_n           (rst_n),
    .addr_i          (m_addr),
    .burstcount_i    (m_burstcount),
    .read_i          (m_read),
    .write_i         (m_write),
    .writedata_i     (m_writedata),
    .readdata_o      (m_readdata),
    .waitrequest_o   (m_waitrequest),
    .readdatavalid_o (m_readdatavalid)
  );

  task automatic add_entry(input string name, input op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_wdata.push_back(wdata);
    tbl_be.push_back(be);
  endtask

  // 16 lines of 4 words with the index in addr[7:4]
  task automatic build_table();
    logic [31:0] addr;
    add_entry("a_cold_rd", OP_A_RD, 32'h0000_1004, '0, '0);
    add_entry("a_hit_rd", OP_A_RD, 32'h0000_1008, '0, '0);
    add_entry("a_part_wr", OP_A_WR, 32'h0000_1008, 32'hDEAD_BEEF, 4'b0101);
    add_entry("a_merge_rd", OP_A_RD, 32'h0000_1008, '0, '0);
    add_entry("a_evict_rd", OP_A_RD, 32'h0000_2008, '0, '0);  // dirty victim out
    add_entry("a_back_rd", OP_A_RD, 32'h0000_1008, '0, '0);
    add_entry("b_hit_rd", OP_B_RD, 32'h0000_1000, '0, '0);
    add_entry("a_miss_wr", OP_A_WR, 32'h0000_3050, 32'h1234_5678, 4'b1111);
    add_entry("b_dirty_rd", OP_B_RD, 32'h0000_3050, '0, '0);
    add_entry("b_evict_rd", OP_B_RD, 32'h0000_4054, '0, '0);
    add_entry("b_back_rd", OP_B_RD, 32'h0000_3050, '0, '0);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = {16'h0000, 8'(8 + $urandom_range(3)), 4'($urandom_range(15)),
              2'($urandom_range(3)), 2'b00};
      add_entry($sformatf("rnd_%0d", i), op_e'($urandom_range(2)), addr, $urandom,
                4'($urandom_range(15, 1)));
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (shadow.exists(addr[31:2])) begin
      return shadow[addr[31:2]];
    end
    return {2'b00, addr[31:2]} ^ 32'h5A5A_0000;  // initial memory content
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %08h actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      $display("%-12s ok", name);
    end else begin
      $display("%-12s failed", name);
      failed_tests++;
    end
  endtask

  task automatic run_entry(input int n);
    logic [31:0] got;
    logic [31:0] merged;
    logic [3:0]  idx;
    bit          expect_hit;
    int          cycles;
    int          errors_before;
    bit          done;
    errors_before = errors;
    idx           = tbl_addr[n][7:4];
    expect_hit    = line_valid[idx] && (line_tag[idx] == tbl_addr[n][31:8]);
    @(posedge clk);
    #1;
    case (tbl_op[n])
      OP_A_RD: begin
        a_addr = tbl_addr[n];
        a_read = 1'b1;
      end
      OP_A_WR: begin
        a_addr       = tbl_addr[n];
        a_writedata  = tbl_wdata[n];
        a_byteenable = tbl_be[n];
        a_write      = 1'b1;
      end
      default: begin
        b_addr = tbl_addr[n];
        b_read = 1'b1;
      end
    endcase
    cycles = 0;
    done   = 1'b0;
    got    = '0;
    while (!done && cycles < ENTRY_CYCLES) begin
      @(negedge clk);  // hit outputs settled
      if (tbl_op[n] == OP_B_RD) begin
        done = !b_waitrequest;
        got  = b_readdata;
      end else begin
        done = !a_waitrequest;
        got  = a_readdata;
      end
      cycles++;
    end
    if (!done) begin
      $display("%s: waitrequest still high after %0d cycles", tbl_name[n], cycles);
      errors++;
    end else begin
      // a hit drops waitrequest in the request cycle
      check_value({tbl_name[n], " hit"}, 32'(expect_hit), 32'(cycles == 1));
      line_tag[idx]   = tbl_addr[n][31:8];
      line_valid[idx] = 1'b1;
      if (tbl_op[n] == OP_A_WR) begin
        merged = expected_word(tbl_addr[n]);
        for (int i = 0; i < 4; i++) begin
          if (tbl_be[n][i]) begin
            merged[8*i +: 8] = tbl_wdata[n][8*i +: 8];
          end
        end
        shadow[tbl_addr[n][31:2]] = merged;
      end else begin
        check_value(tbl_name[n], expected_word(tbl_addr[n]), got);
      end
    end
    @(posedge clk);  // write commits on this edge
    #1;
    a_read  = 1'b0;
    a_write = 1'b0;
    b_read  = 1'b0;
    report_test(tbl_name[n], errors == errors_before);
  endtask

  initial begin
    wait (table_ready);
    repeat (RESET_CYCLES + (tbl_op.size() + 1) * ENTRY_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish in the allowed time");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h8925));
    a_addr       = '0;
    a_read       = 1'b0;
    a_write      = 1'b0;
    a_writedata  = '0;
    a_byteenable = '0;
    b_addr       = '0;
    b_read       = 1'b0;
    errors       = 0;
    failed_tests = 0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("reset_idle", 32'h0, {28'h0, a_waitrequest, b_waitrequest, m_read, m_write});
    report_test("reset_idle", errors == 0);
    for (int n = 0; n < tbl_op.size(); n++) begin
      run_entry(n);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tbl_op.size() + 1,
             tbl_op.size() + 1 - failed_tests, failed_tests, errors);
    if (failed_tests == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/cache_pkg.sv
source/cache_line.sv
source/line_refill_ctrl.sv
source/cache_core.sv
bench/clk_gen.sv
bench/avalon_mem_model.sv
bench/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cache -o tb_cache_sim -f files.f \
  && { ./obj_dir/tb_cache_sim > sim.log 2>&1 || true; } \
  && grep -qx "TB PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
